/* include/castle_settings.svh */
// Build-time sizes for the main-CPU board glue
// Included by the package and by any module that sizes logic from these macros
// ROM and RAM widths follow the dumped board, 32kB fixed plus 128kB banked
`ifndef CASTLE_SETTINGS_SVH
`define CASTLE_SETTINGS_SVH

// ROM byte address, bit 15 plus 4 bank bits plus 13 offset bits
`define CASTLE_ROM_AW 18

// 8 kB work RAM
`define CASTLE_RAM_AW 13

// Clock-enable ratio NUM/DEN applied to clk for the fast enable
`define CASTLE_CEN_NUM 1
`define CASTLE_CEN_DEN 2

`endif

/* logic/castle_pkg.sv */
// Shared vector types for the main-CPU board glue
// Referenced by scoped name from every RTL file
// Widths of ROM and RAM addresses come from the settings header
package castle_pkg;

`include "castle_settings.svh"

    // CPU side address bus, 64 kB space
    typedef logic [15:0] cpu_addr_t;

    // Every data path on the board is a byte
    typedef logic [7:0] byte_t;

    // Banked ROM byte address
    typedef logic [`CASTLE_ROM_AW-1:0] rom_addr_t;

    // Work RAM word address
    typedef logic [`CASTLE_RAM_AW-1:0] ram_addr_t;

    // ROM bank register
    // Schematic shows 5 bits, top one never used
    typedef logic [3:0] bank_t;

endpackage

/* logic/cen_gen.sv */
// Fractional clock-enable generator for the main CPU
// cen24 fires at NUM/DEN of clk, cen12 on every second cen24
// Both are single-clk pulses, cen12 only ever coincides with cen24
`include "castle_settings.svh"

module cen_gen (
    input  logic clk,
    input  logic rst,
    output logic cen24,
    output logic cen12
);

    // Accumulator wide enough for DEN-1 plus NUM
    localparam int CW = $clog2(`CASTLE_CEN_DEN + `CASTLE_CEN_NUM + 1);

    logic [CW-1:0] acc;
    logic [CW-1:0] acc_sum;
    logic          half;

    // Next accumulator value before the wrap test
    assign acc_sum = acc + CW'(`CASTLE_CEN_NUM);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            acc   <= '0;
            half  <= 1'b0;
            cen24 <= 1'b0;
            cen12 <= 1'b0;
        end else begin
            cen24 <= 1'b0;
            cen12 <= 1'b0;
            if (acc_sum >= CW'(`CASTLE_CEN_DEN)) begin
                // Wrap gives one fast pulse
                acc   <= acc_sum - CW'(`CASTLE_CEN_DEN);
                cen24 <= 1'b1;
                // Divide by two for the CPU rate
                half  <= ~half;
                cen12 <= half;
            end else begin
                acc <= acc_sum;
            end
        end
    end

    // Slow enable must sit on a fast enable
    cen12_in_cen24: assert property (@(posedge clk) disable iff (rst) cen12 |-> cen24)
        else $error("cen12 pulsed without cen24");

endmodule

/* logic/main_decoder.sv */
// Main CPU address decoder
// Turns the CPU address into chip selects and the banked ROM address,
// and muxes the read data back to the CPU by fixed priority
// Purely combinational, all outputs settle with the address
module main_decoder (
    input  castle_pkg::cpu_addr_t cpu_addr,
    input  logic                  cpu_we,
    input  castle_pkg::bank_t     bank,
    input  castle_pkg::byte_t     rom_data,
    input  castle_pkg::byte_t     ram_dout,
    input  castle_pkg::byte_t     port_dout,
    input  castle_pkg::byte_t     pal_dout,
    input  castle_pkg::byte_t     gfx1_dout,
    input  castle_pkg::byte_t     gfx2_dout,
    input  logic                  rom_ok,
    output logic                  gfx1_cs,
    output logic                  gfx2_cs,
    output logic                  pal_cs,
    output logic                  io_cs,
    output logic                  ram_cs,
    output logic                  rom_cs,
    output castle_pkg::rom_addr_t rom_addr,
    output castle_pkg::byte_t     cpu_din,
    output logic                  dtack
);

    // High address byte
    castle_pkg::byte_t page;
    // Four bank bits of the ROM address
    castle_pkg::bank_t rom_page;

    assign page = cpu_addr[15:8];

    always_comb begin
        // Graphics chips, one register page plus an 8 kB window each
        gfx1_cs = (page == 8'h00) || (cpu_addr[15:13] == 3'd1);
        gfx2_cs = (page == 8'h02) || (cpu_addr[15:13] == 3'd2);
        io_cs   = (page == 8'h04);
        pal_cs  = (page == 8'h06);
        // Work RAM spans pages 07 to 1F
        ram_cs  = (page >= 8'h07) && (page < 8'h20);
        // ROM is read-only from 6000 up
        rom_cs  = (cpu_addr[15:12] >= 4'h6) && !cpu_we;
    end

    // Lower half of ROM space is banked, upper 32 kB maps straight through
    assign rom_page = cpu_addr[15] ? {2'b00, cpu_addr[14:13]} : bank;
    assign rom_addr = {cpu_addr[15], rom_page, cpu_addr[12:0]};

    // Read-data priority
    always_comb begin
        if (rom_cs) begin
            cpu_din = rom_data;
        end else if (ram_cs) begin
            cpu_din = ram_dout;
        end else if (io_cs) begin
            cpu_din = port_dout;
        end else if (pal_cs) begin
            cpu_din = pal_dout;
        end else if (gfx1_cs) begin
            cpu_din = gfx1_dout;
        end else if (gfx2_cs) begin
            cpu_din = gfx2_dout;
        end else begin
            // Open bus
            cpu_din = 8'hff;
        end
    end

    // CPU waits only on slow ROM fetches
    assign dtack = ~rom_cs | rom_ok;

    // I/O, palette and RAM pages are disjoint
    always_comb begin
        sel_disjoint: assert #0 ($onehot0({io_cs, pal_cs, ram_cs}))
            else $error("overlapping io/pal/ram selects");
    end

endmodule

/* logic/main_io.sv */
// Board I/O register block of the main CPU
// Holds ROM bank, sound latch and IRQ, video bank and priority,
// and registers the selected cabinet or DIP port for CPU reads
// Offset is address bits 4:2, port data is valid one clk after io_cs
module main_io (
    input  logic              clk,
    input  logic              rst,
    input  logic              io_cs,
    input  logic              cpu_we,
    input  logic [4:0]        io_addr,
    input  castle_pkg::byte_t cpu_dout,
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic [6:0]        joystick1,
    input  logic [6:0]        joystick2,
    input  logic              service,
    input  castle_pkg::byte_t dipsw_a,
    input  castle_pkg::byte_t dipsw_b,
    input  logic [3:0]        dipsw_c,
    input  logic              snd_ack,
    output castle_pkg::bank_t bank,
    output castle_pkg::byte_t snd_latch,
    output logic              snd_irq,
    output logic [1:0]        video_bank,
    output logic              prio,
    output castle_pkg::byte_t port_dout
);

    logic [2:0] offset;
    logic       wr_en;

    assign offset = io_addr[4:2];
    assign wr_en  = io_cs & cpu_we;

    // Write registers and read port
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bank       <= '0;
            snd_latch  <= '0;
            video_bank <= '0;
            prio       <= 1'b0;
            port_dout  <= '0;
        end else if (io_cs) begin
            case (offset)
                3'd0: if (wr_en) bank <= cpu_dout[3:0];
                3'd1: if (wr_en) snd_latch <= cpu_dout;
                // Cabinet inputs, sub-port on bits 1:0
                3'd4: begin
                    case (io_addr[1:0])
                        2'd0: port_dout <= {3'b111, start_button, service, coin_input};
                        2'd1: port_dout <= {2'b11, joystick1[5:0]};
                        2'd2: port_dout <= {2'b11, joystick2[5:0]};
                        default: begin
                            port_dout <= {2'b11, joystick2[6], joystick1[6], dipsw_c};
                        end
                    endcase
                end
                3'd5: port_dout <= io_addr[0] ? dipsw_b : dipsw_a;
                3'd6: begin
                    if (wr_en) {prio, video_bank} <= cpu_dout[2:0];
                    // Readback sees the old value on a write cycle
                    port_dout <= {5'd0, prio, video_bank};
                end
                default: ;
            endcase
            // Everything but 4 to 6 reads open bus
            if (offset < 3'd4 || offset == 3'd7) begin
                port_dout <= 8'hff;
            end
        end
    end

    // Sound IRQ, set by a write, dropped on ack, set has priority
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            snd_irq <= 1'b0;
        end else if (wr_en && offset == 3'd2) begin
            snd_irq <= 1'b1;
        end else if (snd_ack) begin
            snd_irq <= 1'b0;
        end
    end

    // Latch moves only after a latch write
    latch_on_write: assert property (@(posedge clk) disable iff (rst)
        !$stable(snd_latch) |-> $past(io_cs && cpu_we && offset == 3'd1))
        else $error("snd_latch changed without a write");

endmodule

/* logic/work_ram.sv */
// Main CPU work RAM, 8 kB single port
// Write on the clock edge with we high, read data one clk after the address
// Read returns the old contents on a write cycle
`include "castle_settings.svh"

module work_ram (
    input  logic                  clk,
    input  castle_pkg::ram_addr_t ram_addr,
    input  logic                  we,
    input  castle_pkg::byte_t     din,
    output castle_pkg::byte_t     dout
);

    localparam int DEPTH = 2 ** `CASTLE_RAM_AW;

    // Storage array
    castle_pkg::byte_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[ram_addr] <= din;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        dout <= mem[ram_addr];
    end

endmodule

/* logic/castle_main.sv */
// Main-CPU board glue of the castle game core
// The CPU bus comes in as ports, chip selects and data go to the
// sound, video and ROM blocks outside
// cpu_cen paces the CPU at a quarter of clk
module castle_main (
    input  logic                  clk,
    input  logic                  rst,
    // CPU bus
    input  castle_pkg::cpu_addr_t cpu_addr,
    input  castle_pkg::byte_t     cpu_dout,
    input  logic                  cpu_we,
    output castle_pkg::byte_t     cpu_din,
    output logic                  dtack,
    output logic                  cpu_cen,
    // ROM
    output castle_pkg::rom_addr_t rom_addr,
    output logic                  rom_cs,
    input  castle_pkg::byte_t     rom_data,
    input  logic                  rom_ok,
    // Video chips and palette
    output logic                  gfx1_cs,
    output logic                  gfx2_cs,
    output logic                  pal_cs,
    input  castle_pkg::byte_t     pal_dout,
    input  castle_pkg::byte_t     gfx1_dout,
    input  castle_pkg::byte_t     gfx2_dout,
    output logic [1:0]            video_bank,
    output logic                  prio,
    // Sound CPU link
    output logic                  snd_irq,
    output castle_pkg::byte_t     snd_latch,
    input  logic                  snd_ack,
    // Cabinet
    input  logic [1:0]            start_button,
    input  logic [1:0]            coin_input,
    input  logic [6:0]            joystick1,
    input  logic [6:0]            joystick2,
    input  logic                  service,
    // DIP switches
    input  castle_pkg::byte_t     dipsw_a,
    input  castle_pkg::byte_t     dipsw_b,
    input  logic [3:0]            dipsw_c
);

    logic              io_cs;
    logic              ram_cs;
    castle_pkg::bank_t bank;
    castle_pkg::byte_t port_dout;
    castle_pkg::byte_t ram_dout;

    // CPU rate enable, fast enable only used inside
    cen_gen cen_inst (
        .clk   (clk),
        .rst   (rst),
        .cen24 (),
        .cen12 (cpu_cen)
    );

    main_decoder decoder_inst (
        .cpu_addr  (cpu_addr),
        .cpu_we    (cpu_we),
        .bank      (bank),
        .rom_data  (rom_data),
        .ram_dout  (ram_dout),
        .port_dout (port_dout),
        .pal_dout  (pal_dout),
        .gfx1_dout (gfx1_dout),
        .gfx2_dout (gfx2_dout),
        .rom_ok    (rom_ok),
        .gfx1_cs   (gfx1_cs),
        .gfx2_cs   (gfx2_cs),
        .pal_cs    (pal_cs),
        .io_cs     (io_cs),
        .ram_cs    (ram_cs),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .cpu_din   (cpu_din),
        .dtack     (dtack)
    );

    main_io io_inst (
        .clk          (clk),
        .rst          (rst),
        .io_cs        (io_cs),
        .cpu_we       (cpu_we),
        .io_addr      (cpu_addr[4:0]),
        .cpu_dout     (cpu_dout),
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .snd_ack      (snd_ack),
        .bank         (bank),
        .snd_latch    (snd_latch),
        .snd_irq      (snd_irq),
        .video_bank   (video_bank),
        .prio         (prio),
        .port_dout    (port_dout)
    );

    // RAM sits on the low 13 address bits
    work_ram ram_inst (
        .clk      (clk),
        .ram_addr (cpu_addr[12:0]),
        .we       (ram_cs & cpu_we),
        .din      (cpu_dout),
        .dout     (ram_dout)
    );

endmodule

/* verif/castle_main_tb.sv */
// Directed testbench for the main-CPU board glue
// Tasks play the CPU on the falling clock edge and check decode, banking, RAM and I/O
module castle_main_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                  clk;
    logic                  rst;
    castle_pkg::cpu_addr_t cpu_addr;
    castle_pkg::byte_t     cpu_dout;
    castle_pkg::byte_t     cpu_din;
    castle_pkg::byte_t     rom_data;
    castle_pkg::byte_t     pal_dout;
    castle_pkg::byte_t     gfx1_dout;
    castle_pkg::byte_t     gfx2_dout;
    castle_pkg::byte_t     snd_latch;
    castle_pkg::byte_t     dipsw_a;
    castle_pkg::byte_t     dipsw_b;
    castle_pkg::rom_addr_t rom_addr;
    logic                  cpu_we;
    logic                  dtack;
    logic                  cpu_cen;
    logic                  rom_cs;
    logic                  rom_ok;
    logic                  gfx1_cs;
    logic                  gfx2_cs;
    logic                  pal_cs;
    logic                  snd_irq;
    logic                  snd_ack;
    logic                  prio;
    logic                  service;
    logic [1:0]            video_bank;
    logic [1:0]            start_button;
    logic [1:0]            coin_input;
    logic [6:0]            joystick1;
    logic [6:0]            joystick2;
    logic [3:0]            dipsw_c;
    int                    errors;
    int                    fails;
    int                    tests;

    castle_main castle_main_inst (.*);

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic castle_pkg::byte_t rand_byte();
        return 8'($urandom);
    endfunction

    task automatic report(input string name, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("CHECK FAILED at %0t ns: %s got 0x%0h, expected 0x%0h",
                 $time, name, got, exp);
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            fails++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // One CPU write with the strobe held over one rising edge
    // Bus goes back to an idle page afterwards
    task automatic bus_write(input castle_pkg::cpu_addr_t addr, input castle_pkg::byte_t data);
        @(negedge clk);
        cpu_addr = addr;
        cpu_dout = data;
        cpu_we   = 1'b1;
        @(negedge clk);
        cpu_we   = 1'b0;
        cpu_addr = 16'h0500;
    endtask

    // One CPU read sampled after at least one rising edge once dtack is high
    task automatic bus_read(input castle_pkg::cpu_addr_t addr, output castle_pkg::byte_t data);
        int n;
        @(negedge clk);
        cpu_addr = addr;
        cpu_we   = 1'b0;
        @(negedge clk);
        n = 0;
        while (!dtack && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!dtack) begin
            errors++;
            $display("Timeout at %0t ns: dtack stayed low on a read of 0x%h", $time, addr);
        end
        data = cpu_din;
    endtask

    task automatic reset_values();
        int e0;
        int n;
        e0 = errors;
        if (snd_irq !== 1'b0) report("snd_irq", snd_irq, 0);
        if (snd_latch !== 8'h00) report("snd_latch", snd_latch, 0);
        if (video_bank !== 2'd0) report("video_bank", video_bank, 0);
        if (prio !== 1'b0) report("prio", prio, 0);
        // First CPU enable then one in every four clocks
        n = 0;
        while (!cpu_cen && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (!cpu_cen) begin
            errors++;
            $display("Timeout: cpu_cen never pulsed after reset");
        end
        for (int i = 1; i <= 12; i++) begin
            @(negedge clk);
            if (cpu_cen !== (i % 4 == 0)) report("cpu_cen", cpu_cen, i % 4 == 0);
        end
        end_test("reset", e0);
    endtask

    // Select bits are {gfx1, gfx2, pal, rom}
    // src 0 gfx1, 1 gfx2, 2 pal, 3 rom, 4 open bus, 5 no data check
    task automatic probe(input castle_pkg::cpu_addr_t addr, input logic we,
                         input logic [3:0] exp_cs, input int src);
        castle_pkg::byte_t exp_din;
        @(negedge clk);
        cpu_addr  = addr;
        cpu_we    = we;
        gfx1_dout = rand_byte();
        gfx2_dout = rand_byte();
        pal_dout  = rand_byte();
        rom_data  = rand_byte();
        case (src)
            0: exp_din = gfx1_dout;
            1: exp_din = gfx2_dout;
            2: exp_din = pal_dout;
            3: exp_din = rom_data;
            default: exp_din = 8'hff;
        endcase
        @(negedge clk);
        if ({gfx1_cs, gfx2_cs, pal_cs, rom_cs} !== exp_cs) begin
            report("gfx1_cs,gfx2_cs,pal_cs,rom_cs", {gfx1_cs, gfx2_cs, pal_cs, rom_cs}, exp_cs);
        end
        if (src < 5 && cpu_din !== exp_din) report("cpu_din", cpu_din, exp_din);
        cpu_we = 1'b0;
    endtask

    task automatic decode_map();
        int e0;
        e0 = errors;
        probe(16'h0012, 1'b0, 4'b1000, 0);
        probe(16'h2abc, 1'b0, 4'b1000, 0);
        probe(16'h0234, 1'b0, 4'b0100, 1);
        probe(16'h5def, 1'b0, 4'b0100, 1);
        probe(16'h0611, 1'b0, 4'b0010, 2);
        // I/O and RAM pages drive no external select
        probe(16'h0400, 1'b0, 4'b0000, 5);
        probe(16'h1234, 1'b0, 4'b0000, 5);
        probe(16'h0100, 1'b0, 4'b0000, 4);
        probe(16'h0500, 1'b0, 4'b0000, 4);
        probe(16'h6000, 1'b0, 4'b0001, 3);
        probe(16'hfff0, 1'b0, 4'b0001, 3);
        // ROM space is read only
        probe(16'h9000, 1'b1, 4'b0000, 5);
        end_test("decode", e0);
    endtask

    task automatic rom_banking();
        int                    e0;
        int                    wait_n;
        castle_pkg::byte_t     b;
        castle_pkg::byte_t     got;
        castle_pkg::cpu_addr_t a;
        castle_pkg::rom_addr_t exp_ra;
        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            b = rand_byte();
            bus_write(16'h0400, b);
            // Even passes hit the banked window, odd passes the fixed half
            if (i % 2 == 0) begin
                a      = 16'h6000 | 16'($urandom & 32'h1fff);
                exp_ra = {1'b0, b[3:0], a[12:0]};
            end else begin
                a      = 16'h8000 | 16'($urandom & 32'h7fff);
                exp_ra = {1'b1, 2'b00, a[14:13], a[12:0]};
            end
            wait_n = 1 + $urandom % 5;
            @(negedge clk);
            cpu_addr = a;
            rom_ok   = 1'b0;
            rom_data = rand_byte();
            // Slow ROM holds the CPU
            repeat (wait_n) begin
                @(negedge clk);
                if (rom_addr !== exp_ra) report("rom_addr", rom_addr, exp_ra);
                if (dtack !== 1'b0) report("dtack", dtack, 0);
            end
            rom_ok = 1'b1;
            bus_read(a, got);
            if (got !== rom_data) report("cpu_din", got, rom_data);
        end
        end_test("banking", e0);
    endtask

    task automatic ram_readback();
        int                    e0;
        castle_pkg::byte_t     model [castle_pkg::ram_addr_t];
        castle_pkg::cpu_addr_t addrs [$];
        castle_pkg::cpu_addr_t a;
        castle_pkg::byte_t     d;
        castle_pkg::byte_t     got;
        e0 = errors;
        for (int i = 0; i < 24; i++) begin
            // Pages 07 to 1F
            a = 16'h0700 + 16'($urandom % 32'h1900);
            d = rand_byte();
            bus_write(a, d);
            model[a[12:0]] = d;
            addrs.push_back(a);
        end
        foreach (addrs[i]) begin
            a = addrs[i];
            bus_read(a, got);
            if (got !== model[a[12:0]]) report("cpu_din", got, model[a[12:0]]);
        end
        end_test("ram", e0);
    endtask

    task automatic randomize_inputs();
        start_button = 2'($urandom);
        coin_input   = 2'($urandom);
        service      = 1'($urandom);
        joystick1    = 7'($urandom);
        joystick2    = 7'($urandom);
        dipsw_a      = rand_byte();
        dipsw_b      = rand_byte();
        dipsw_c      = 4'($urandom);
    endtask

    task automatic io_registers();
        int                e0;
        castle_pkg::byte_t d;
        castle_pkg::byte_t got;
        castle_pkg::byte_t exp;
        e0 = errors;
        d = rand_byte();
        bus_write(16'h0404, d);
        if (snd_latch !== d) report("snd_latch", snd_latch, d);
        bus_write(16'h0408, rand_byte());
        if (snd_irq !== 1'b1) report("snd_irq", snd_irq, 1);
        // Ack alone clears
        snd_ack = 1'b1;
        @(negedge clk);
        snd_ack = 1'b0;
        if (snd_irq !== 1'b0) report("snd_irq", snd_irq, 0);
        // Set wins over an ack on the same edge
        snd_ack = 1'b1;
        bus_write(16'h0408, 8'h00);
        snd_ack = 1'b0;
        if (snd_irq !== 1'b1) report("snd_irq", snd_irq, 1);
        d = rand_byte();
        bus_write(16'h0418, d);
        if ({prio, video_bank} !== d[2:0]) report("prio,video_bank", {prio, video_bank}, d[2:0]);
        bus_read(16'h0418, got);
        if (got !== {5'd0, d[2:0]}) report("cpu_din", got, {5'd0, d[2:0]});
        // Cabinet ports
        for (int p = 0; p < 4; p++) begin
            randomize_inputs();
            bus_read(16'h0410 + 16'(p), got);
            case (p)
                0: exp = {3'b111, start_button, service, coin_input};
                1: exp = {2'b11, joystick1[5:0]};
                2: exp = {2'b11, joystick2[5:0]};
                default: exp = {2'b11, joystick2[6], joystick1[6], dipsw_c};
            endcase
            if (got !== exp) report("cpu_din", got, exp);
        end
        randomize_inputs();
        bus_read(16'h0414, got);
        if (got !== dipsw_a) report("cpu_din", got, dipsw_a);
        bus_read(16'h0415, got);
        if (got !== dipsw_b) report("cpu_din", got, dipsw_b);
        // Unused offsets
        bus_read(16'h040c, got);
        if (got !== 8'hff) report("cpu_din", got, 8'hff);
        bus_read(16'h041c, got);
        if (got !== 8'hff) report("cpu_din", got, 8'hff);
        end_test("io", e0);
    endtask

    initial begin
        void'($urandom(32'h206d_f923));
        errors       = 0;
        fails        = 0;
        tests        = 0;
        rst          = 1'b1;
        cpu_addr     = 16'h0500;
        cpu_dout     = 8'h00;
        cpu_we       = 1'b0;
        rom_data     = 8'h00;
        rom_ok       = 1'b1;
        pal_dout     = 8'h00;
        gfx1_dout    = 8'h00;
        gfx2_dout    = 8'h00;
        snd_ack      = 1'b0;
        start_button = 2'b00;
        coin_input   = 2'b00;
        service      = 1'b0;
        joystick1    = 7'd0;
        joystick2    = 7'd0;
        dipsw_a      = 8'h00;
        dipsw_b      = 8'h00;
        dipsw_c      = 4'h0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_values();
        decode_map();
        rom_banking();
        ram_readback();
        io_registers();
        $display("%0d tests run, %0d failed, %0d errors", tests, fails, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* castle_main.f */
+incdir+include
logic/castle_pkg.sv
logic/cen_gen.sv
logic/main_decoder.sv
logic/main_io.sv
logic/work_ram.sv
logic/castle_main.sv
verif/castle_main_tb.sv
